/* src/nes_bus_pkg.sv */
package nes_bus_pkg;

    // PPU register selects with 0..7 taken from CPU address bits 2..0
    typedef enum logic [3:0] {
        PPUCTRL   = 4'd0,
        PPUMASK   = 4'd1,
        PPUSTATUS = 4'd2,
        OAMADDR   = 4'd3,
        OAMDATA   = 4'd4,
        PPUSCROLL = 4'd5,
        PPUADDR   = 4'd6,
        PPUDATA   = 4'd7,
        OAMDMA    = 4'd8
    } reg_t;

    // Region of the CPU address map hit by an access
    typedef enum logic [2:0] {
        REGION_RAM     = 3'd0,
        REGION_PPU     = 3'd1,
        REGION_PAD1    = 3'd2,
        REGION_PAD2    = 3'd3,
        REGION_PRG_RAM = 3'd4,
        REGION_NONE    = 3'd5
    } bus_region_t;

endpackage : nes_bus_pkg

/* src/bus_decoder.sv */
module bus_decoder
    import nes_bus_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        clock_en,
    input  logic [15:0] addr,
    input  logic        r_en,
    output bus_region_t region,
    output reg_t        reg_sel,
    output logic        reg_en,
    output logic        reg_rw,
    input  logic [7:0]  mem_data,
    input  logic [7:0]  pad_data,
    input  logic [7:0]  reg_data_rd,
    output logic [7:0]  r_data
);

    bus_region_t prev_region;

    // Address map
    always_comb begin
        if (addr < 16'h2000) begin
            region = REGION_RAM;
        end else if (addr < 16'h4000) begin
            region = REGION_PPU;
        end else if (addr == 16'h4014) begin
            region = REGION_PPU;
        end else if (addr == 16'h4016) begin
            region = REGION_PAD1;
        end else if (addr == 16'h4017) begin
            region = REGION_PAD2;
        end else if (addr >= 16'h6000 && addr < 16'h8000) begin
            region = REGION_PRG_RAM;
        end else begin
            region = REGION_NONE;
        end
    end

    // PPU register port
    assign reg_en = (region == REGION_PPU);
    assign reg_rw = ~r_en;

    always_comb begin
        reg_sel = PPUCTRL;
        if (reg_en) begin
            if (addr == 16'h4014) begin
                reg_sel = OAMDMA;
            end else begin
                reg_sel = reg_t'({1'b0, addr[2:0]});
            end
        end
    end

    // Remember where the last read went
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            prev_region <= REGION_NONE;
        end else if (clock_en && r_en) begin
            prev_region <= region;
        end
    end

    // Read data mux
    always_comb begin
        case (prev_region)
            REGION_PAD1, REGION_PAD2: r_data = pad_data;
            REGION_PPU:               r_data = reg_data_rd;
            default:                  r_data = mem_data;
        endcase
    end

endmodule : bus_decoder

/* src/memory_store.sv */
module memory_store
    import nes_bus_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH     = 11,
    parameter int PRG_RAM_ADDR_WIDTH = 13
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        clock_en,
    input  bus_region_t region,
    input  logic [15:0] addr,
    input  logic        r_en,
    input  logic [7:0]  w_data,
    output logic [7:0]  mem_data
);

    localparam int RAM_DEPTH     = 1 << RAM_ADDR_WIDTH;
    localparam int PRG_RAM_DEPTH = 1 << PRG_RAM_ADDR_WIDTH;

    logic [7:0] work_ram [RAM_DEPTH];
    logic [7:0] prg_ram  [PRG_RAM_DEPTH];

    logic [RAM_ADDR_WIDTH-1:0]     ram_index;
    logic [PRG_RAM_ADDR_WIDTH-1:0] prg_index;
    logic                          ram_hit;
    logic                          prg_hit;

    // Upper address bits dropped so the arrays mirror
    assign ram_index = addr[RAM_ADDR_WIDTH-1:0];
    assign prg_index = addr[PRG_RAM_ADDR_WIDTH-1:0];

    assign ram_hit = (region == REGION_RAM);
    assign prg_hit = (region == REGION_PRG_RAM);

    // Array writes
    always_ff @(posedge clock) begin
        if (clock_en && !r_en) begin
            if (ram_hit) begin
                work_ram[ram_index] <= w_data;
            end
            if (prg_hit) begin
                prg_ram[prg_index] <= w_data;
            end
        end
    end

    // Registered read word that holds when nothing is read here
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_data <= 8'd0;
        end else if (clock_en && r_en) begin
            if (ram_hit) begin
                mem_data <= work_ram[ram_index];
            end else if (prg_hit) begin
                mem_data <= prg_ram[prg_index];
            end
        end
    end

endmodule : memory_store

/* src/controller_port.sv */
module controller_port
    import nes_bus_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    input  logic        clock_en,
    input  bus_region_t region,
    input  logic        r_en,
    input  logic [7:0]  w_data,
    input  logic        ctlr_data_p1,
    input  logic        ctlr_data_p2,
    output logic        ctlr_pulse_p1,
    output logic        ctlr_pulse_p2,
    output logic        ctlr_latch,
    output logic [7:0]  pad_data
);

    logic pad1_rd;
    logic pad2_rd;
    logic pad1_wr;

    assign pad1_rd = (region == REGION_PAD1) && r_en;
    assign pad2_rd = (region == REGION_PAD2) && r_en;
    assign pad1_wr = (region == REGION_PAD1) && !r_en;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ctlr_latch    <= 1'b0;
            ctlr_pulse_p1 <= 1'b1;
            ctlr_pulse_p2 <= 1'b1;
            pad_data      <= 8'd0;
        end else if (clock_en) begin
            // Strobe level follows bit 0 of a $4016 write
            if (pad1_wr) begin
                ctlr_latch <= w_data[0];
            end

            // Shift clock is low for one enabled cycle after a read
            ctlr_pulse_p1 <= ~pad1_rd;
            ctlr_pulse_p2 <= ~pad2_rd;

            // Pad pins are active low
            if (pad1_rd) begin
                pad_data <= {7'd0, ~ctlr_data_p1};
            end else if (pad2_rd) begin
                pad_data <= {7'd0, ~ctlr_data_p2};
            end
        end
    end

endmodule : controller_port

/* src/nes_cpu_bus.sv */
module nes_cpu_bus
    import nes_bus_pkg::*;
#(
    parameter int RAM_ADDR_WIDTH     = 11,
    parameter int PRG_RAM_ADDR_WIDTH = 13
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        clock_en,
    input  logic [15:0] addr,
    input  logic        r_en,
    input  logic [7:0]  w_data,
    output logic [7:0]  r_data,
    output reg_t        reg_sel,
    output logic        reg_en,
    output logic        reg_rw,
    output logic [7:0]  reg_data_wr,
    input  logic [7:0]  reg_data_rd,
    input  logic        ctlr_data_p1,
    input  logic        ctlr_data_p2,
    output logic        ctlr_pulse_p1,
    output logic        ctlr_pulse_p2,
    output logic        ctlr_latch
);

    bus_region_t region;
    logic [7:0]  mem_data;
    logic [7:0]  pad_data;

    // PPU sees CPU write data directly
    assign reg_data_wr = w_data;

    bus_decoder i_bus_decoder (
        .clock,
        .reset_n,
        .clock_en,
        .addr,
        .r_en,
        .region,
        .reg_sel,
        .reg_en,
        .reg_rw,
        .mem_data,
        .pad_data,
        .reg_data_rd,
        .r_data
    );

    memory_store #(
        .RAM_ADDR_WIDTH     (RAM_ADDR_WIDTH),
        .PRG_RAM_ADDR_WIDTH (PRG_RAM_ADDR_WIDTH)
    ) i_memory_store (
        .clock,
        .reset_n,
        .clock_en,
        .region,
        .addr,
        .r_en,
        .w_data,
        .mem_data
    );

    controller_port i_controller_port (
        .clock,
        .reset_n,
        .clock_en,
        .region,
        .r_en,
        .w_data,
        .ctlr_data_p1,
        .ctlr_data_p2,
        .ctlr_pulse_p1,
        .ctlr_pulse_p2,
        .ctlr_latch,
        .pad_data
    );

endmodule : nes_cpu_bus

/* bench/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// 32-bit Fibonacci LFSR with taps 32 22 2 1
logic [31:0] lfsr_state;

// One LFSR step per returned bit
function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    logic        feedback;
    value = 32'd0;
    for (int i = 0; i < count; i++) begin
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        value      = {value[30:0], feedback};
    end
    return value;
endfunction

task automatic fail_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at the first error");
endtask

task automatic check_byte(input string name, input logic [7:0] actual, input logic [7:0] expected);
    if (actual !== expected) begin
        $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
        fail_run();
    end
endtask

task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
        $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
        fail_run();
    end
endtask

task automatic check_reg(input string name, input reg_t actual, input reg_t expected);
    if (actual !== expected) begin
        $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
        fail_run();
    end
endtask

`endif

/* bench/tb_nes_cpu_bus.sv */
module tb_nes_cpu_bus
    import nes_bus_pkg::*;
();

    localparam int RAM_AW     = 11;
    localparam int PRG_AW     = 13;
    localparam int NUM_TRANS  = 4000;
    localparam int WAIT_LIMIT = 64;
    localparam int HALF       = 20;

    logic        clock;
    logic        reset_n;
    logic        clock_en;
    logic [15:0] addr;
    logic        r_en;
    logic [7:0]  w_data;
    logic [7:0]  r_data;
    reg_t        reg_sel;
    logic        reg_en;
    logic        reg_rw;
    logic [7:0]  reg_data_wr;
    logic [7:0]  reg_data_rd;
    logic        ctlr_data_p1;
    logic        ctlr_data_p2;
    logic        ctlr_pulse_p1;
    logic        ctlr_pulse_p2;
    logic        ctlr_latch;

    // Reference model state
    logic [7:0]  exp_ram [1 << RAM_AW];
    logic [7:0]  exp_prg [1 << PRG_AW];
    logic        exp_latch;
    logic        exp_pulse1;
    logic        exp_pulse2;
    logic [7:0]  exp_pad;
    logic [7:0]  exp_mem;
    logic [7:0]  exp_ppu;
    bus_region_t exp_prev;
    logic        ppu_pending;

    `include "tb_checks.svh"

    nes_cpu_bus #(
        .RAM_ADDR_WIDTH     (RAM_AW),
        .PRG_RAM_ADDR_WIDTH (PRG_AW)
    ) i_dut (
        .clock         (clock),
        .reset_n       (reset_n),
        .clock_en      (clock_en),
        .addr          (addr),
        .r_en          (r_en),
        .w_data        (w_data),
        .r_data        (r_data),
        .reg_sel       (reg_sel),
        .reg_en        (reg_en),
        .reg_rw        (reg_rw),
        .reg_data_wr   (reg_data_wr),
        .reg_data_rd   (reg_data_rd),
        .ctlr_data_p1  (ctlr_data_p1),
        .ctlr_data_p2  (ctlr_data_p2),
        .ctlr_pulse_p1 (ctlr_pulse_p1),
        .ctlr_pulse_p2 (ctlr_pulse_p2),
        .ctlr_latch    (ctlr_latch)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #HALF clock = ~clock;
        end
    end

    // Console memory map
    function automatic bus_region_t region_of(input logic [15:0] a);
        if (a < 16'h2000) return REGION_RAM;
        if (a < 16'h4000 || a == 16'h4014) return REGION_PPU;
        if (a == 16'h4016) return REGION_PAD1;
        if (a == 16'h4017) return REGION_PAD2;
        if (a >= 16'h6000 && a < 16'h8000) return REGION_PRG_RAM;
        return REGION_NONE;
    endfunction

    // PPU registers in console order from $2000 to $2007
    function automatic reg_t expected_sel(input logic [15:0] a);
        if (a == 16'h4014) return OAMDMA;
        if (a < 16'h2000 || a >= 16'h4000) return PPUCTRL;
        case (a[2:0])
            3'd0:    return PPUCTRL;
            3'd1:    return PPUMASK;
            3'd2:    return PPUSTATUS;
            3'd3:    return OAMADDR;
            3'd4:    return OAMDATA;
            3'd5:    return PPUSCROLL;
            3'd6:    return PPUADDR;
            default: return PPUDATA;
        endcase
    endfunction

    function automatic logic [7:0] expected_read();
        case (exp_prev)
            REGION_PAD1, REGION_PAD2: return exp_pad;
            REGION_PPU:               return exp_ppu;
            default:                  return exp_mem;
        endcase
    endfunction

    function automatic logic [7:0] fill_pattern(input int index, input logic [7:0] salt);
        return 8'(index) ^ 8'(index >> 8) ^ salt;
    endfunction

    task automatic check_outputs(input logic [15:0] a, input logic rd, input logic [7:0] d);
        check_byte("r_data", r_data, expected_read());
        check_bit("ctlr_latch", ctlr_latch, exp_latch);
        check_bit("ctlr_pulse_p1", ctlr_pulse_p1, exp_pulse1);
        check_bit("ctlr_pulse_p2", ctlr_pulse_p2, exp_pulse2);
        check_bit("reg_en", reg_en, region_of(a) == REGION_PPU);
        check_reg("reg_sel", reg_sel, expected_sel(a));
        check_bit("reg_rw", reg_rw, ~rd);
        check_byte("reg_data_wr", reg_data_wr, d);
    endtask

    task automatic update_model(input logic [15:0] a, input logic rd, input logic [7:0] d);
        bus_region_t hit;
        hit = region_of(a);
        if (!rd) begin
            if (hit == REGION_RAM) exp_ram[a[RAM_AW-1:0]] = d;
            if (hit == REGION_PRG_RAM) exp_prg[a[PRG_AW-1:0]] = d;
            if (hit == REGION_PAD1) exp_latch = d[0];
        end else begin
            if (hit == REGION_RAM) exp_mem = exp_ram[a[RAM_AW-1:0]];
            if (hit == REGION_PRG_RAM) exp_mem = exp_prg[a[PRG_AW-1:0]];
            if (hit == REGION_PAD1) exp_pad = {7'd0, ~ctlr_data_p1};
            if (hit == REGION_PAD2) exp_pad = {7'd0, ~ctlr_data_p2};
            if (hit == REGION_PPU) ppu_pending = 1'b1;
            exp_prev = hit;
        end
        exp_pulse1 = !(rd && hit == REGION_PAD1);
        exp_pulse2 = !(rd && hit == REGION_PAD2);
    endtask

    // Holds one access until an enabled edge takes it
    task automatic do_access(input logic [15:0] a, input logic rd, input logic [7:0] d);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clock);
            addr         = a;
            r_en         = rd;
            w_data       = d;
            clock_en     = (3'(random_bits(3)) != 3'd0);
            ctlr_data_p1 = 1'(random_bits(1));
            ctlr_data_p2 = 1'(random_bits(1));
            // Play the PPU answering last cycle's register read
            if (ppu_pending) begin
                reg_data_rd = 8'(random_bits(8));
                exp_ppu     = reg_data_rd;
                ppu_pending = 1'b0;
            end
            #5;
            check_outputs(a, rd, d);
            @(posedge clock);
            if (clock_en) begin
                update_model(a, rd, d);
                taken = 1'b1;
            end else begin
                waited++;
                if (waited >= WAIT_LIMIT) begin
                    $display("timed out waiting for an enabled clock edge at address 0x%h", a);
                    fail_run();
                end
            end
        end
    endtask

    initial begin
        logic [15:0] a;
        lfsr_state   = 32'hc41b_cae5;
        reset_n      = 1'b0;
        clock_en     = 1'b0;
        addr         = 16'h0000;
        r_en         = 1'b1;
        w_data       = 8'h00;
        reg_data_rd  = 8'h00;
        ctlr_data_p1 = 1'b1;
        ctlr_data_p2 = 1'b1;
        exp_latch    = 1'b0;
        exp_pulse1   = 1'b1;
        exp_pulse2   = 1'b1;
        exp_pad      = 8'h00;
        exp_mem      = 8'h00;
        exp_ppu      = 8'h00;
        exp_prev     = REGION_NONE;
        ppu_pending  = 1'b0;

        repeat (2) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        #5;
        check_outputs(16'h0000, 1'b1, 8'h00);

        // Fill both RAMs through random mirrors
        for (int i = 0; i < (1 << RAM_AW); i++) begin
            a = {3'b000, 13'(random_bits(13))};
            a[RAM_AW-1:0] = RAM_AW'(i);
            do_access(a, 1'b0, fill_pattern(i, 8'h5a));
        end
        for (int i = 0; i < (1 << PRG_AW); i++) begin
            a = {3'b011, 13'(random_bits(13))};
            a[PRG_AW-1:0] = PRG_AW'(i);
            do_access(a, 1'b0, fill_pattern(i, 8'ha5));
        end

        for (int n = 0; n < NUM_TRANS; n++) begin
            case (3'(random_bits(3)))
                3'd0, 3'd1: a = {3'b000, 13'(random_bits(13))};
                3'd2:       a = {3'b011, 13'(random_bits(13))};
                3'd3:       a = {3'b001, 13'(random_bits(13))};
                3'd4:       a = 16'h4014;
                3'd5:       a = {15'h200b, 1'(random_bits(1))};
                3'd6:       a = {3'b010, 13'(random_bits(13))};
                default:    a = {1'b1, 15'(random_bits(15))};
            endcase
            do_access(a, 1'(random_bits(1)), 8'(random_bits(8)));
        end

        // One unmapped write so the last read result is checked
        do_access(16'h5000, 1'b0, 8'h00);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : tb_nes_cpu_bus

/* all.f */
+incdir+bench
src/nes_bus_pkg.sv
src/bus_decoder.sv
src/memory_store.sv
src/controller_port.sv
src/nes_cpu_bus.sv
bench/tb_nes_cpu_bus.sv

/* Makefile */
VERILATOR  ?= verilator
TB_TOP     ?= tb_nes_cpu_bus
RTL_TOP    ?= nes_cpu_bus
FILE_LIST  ?= all.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall
PASS_TEXT  ?= SIMULATION PASSED

RTL_SOURCES := src/nes_bus_pkg.sv src/bus_decoder.sv src/memory_store.sv \
               src/controller_port.sv src/nes_cpu_bus.sv
SOURCES     := $(RTL_SOURCES) bench/tb_nes_cpu_bus.sv bench/tb_checks.svh
SIM_BIN     := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)

clean:
	rm -rf $(BUILD_DIR)
